//--- design/cpu_pkg.sv
package cpu_pkg;

	// datapath widths
	localparam int DATA_W = 32;
	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS = 1 << REG_IDX_W;

	// pc step per instruction word
	localparam int INSTR_BYTES = 4;

	// data memory size and load/store latency
	localparam int DMEM_WORDS = 16;
	localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);
	localparam int LDST_CYCLES = 3;
	localparam int LDST_CNT_W = $clog2(LDST_CYCLES + 1);

	// instruction word layout
	localparam int GROUP_W = 2;
	localparam int GROUP_LSB = 30;
	localparam int OPER_W = 3;
	localparam int OPER_LSB = 27;
	localparam int RA_LSB = 24;
	localparam int RB_LSB = 21;
	localparam int RC_LSB = 18;
	localparam int IMM_W = 16;
	localparam int IMM_LSB = 0;

	// top two bits of the word
	typedef enum logic [GROUP_W-1:0]
	{
		GRP_ALU = 2'd0,
		GRP_CTRL = 2'd1,
		GRP_LOAD = 2'd2,
		GRP_STORE = 2'd3
	} instr_group_e;

	// oper field when group is alu
	typedef enum logic [OPER_W-1:0]
	{
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR = 3'd3,
		OP_XOR = 3'd4,
		OP_ADDI = 3'd5
	} alu_op_e;

	// oper field when group is control flow
	typedef enum logic [OPER_W-1:0]
	{
		OP_JMP = 3'd0,
		OP_BEQZ = 3'd1
	} ctrl_op_e;

	// oper stays raw, its meaning depends on group
	typedef struct packed
	{
		instr_group_e group;
		logic [OPER_W-1:0] oper;
		logic [REG_IDX_W-1:0] ra;
		logic [REG_IDX_W-1:0] rb;
		logic [REG_IDX_W-1:0] rc;
		logic [IMM_W-1:0] imm;
		logic nop;
	} decoded_instr_t;

endpackage

//--- design/issue_if.sv
`timescale 1ns/1ps

interface issue_if;
	import cpu_pkg::*;

	// forward path, fetch/decode to execute
	logic issue_valid;
	decoded_instr_t issue_instr;
	logic [DATA_W-1:0] issue_pc;

	// backward path, execute to fetch/decode
	logic busy;
	logic redirect_valid;
	logic [DATA_W-1:0] redirect_pc;

	modport stage (
		output issue_valid, issue_instr, issue_pc,
		input busy, redirect_valid, redirect_pc
	);

	modport exec (
		input issue_valid, issue_instr, issue_pc,
		output busy, redirect_valid, redirect_pc
	);

endinterface

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input logic [cpu_pkg::DATA_W-1:0] instr,
	output cpu_pkg::decoded_instr_t decoded
);
	import cpu_pkg::*;

	always_comb
	begin
		// group goes straight to the enum
		decoded.group = instr_group_e'(instr[GROUP_LSB +: GROUP_W]);
		// opcode kept raw, exec picks alu or ctrl view
		decoded.oper = instr[OPER_LSB +: OPER_W];

		// register fields
		decoded.ra = instr[RA_LSB +: REG_IDX_W];
		decoded.rb = instr[RB_LSB +: REG_IDX_W];
		decoded.rc = instr[RC_LSB +: REG_IDX_W];

		// low half, zero extended later in exec
		decoded.imm = instr[IMM_LSB +: IMM_W];

		// all-zero word is padding in the program area
		decoded.nop = (instr == '0);
	end

endmodule

//--- design/fetch_decode_stage.sv
`timescale 1ns/1ps

module fetch_decode_stage (
	input logic clk,
	input logic rst,
	output logic fetch_req,
	output logic [cpu_pkg::DATA_W-1:0] fetch_addr,
	input logic fetch_ack,
	input logic [cpu_pkg::DATA_W-1:0] fetch_data,
	issue_if.stage iss
);
	import cpu_pkg::*;

	typedef enum logic [1:0]
	{
		ST_REQ,
		ST_WAIT_ACK_LOW,
		ST_HOLD,
		ST_CHANGE_PC
	} state_e;

	state_e state;

	// speculative pc, also the fetch address
	logic [DATA_W-1:0] pc;

	decoded_instr_t decoded;
	decoded_instr_t held_instr;
	decoded_instr_t issue_src;

	logic ack_seen;
	logic issue_now;

	instr_decoder u_decoder (
		.instr(fetch_data),
		.decoded(decoded)
	);

	// address only changes between requests
	assign fetch_addr = pc;

	// word arrives this cycle
	assign ack_seen = (state == ST_REQ) && fetch_req && fetch_ack;

	// issue straight from memory, or from the hold register once busy drops
	assign issue_now = (ack_seen && !decoded.nop && !iss.busy)
		|| ((state == ST_HOLD) && !iss.busy);
	assign issue_src = (state == ST_HOLD) ? held_instr : decoded;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_REQ;
			pc <= '0;
			fetch_req <= 1'b0;
			iss.issue_valid <= 1'b0;
		end
		else
		begin
			iss.issue_valid <= issue_now;

			case (state)
			ST_REQ:
			begin
				// raise request only after ack is gone
				if (!fetch_req && !fetch_ack)
				begin
					fetch_req <= 1'b1;
				end
				if (ack_seen)
				begin
					fetch_req <= 1'b0;
					if (decoded.nop)
					begin
						// padding word, skip it
						pc <= pc + INSTR_BYTES;
						state <= ST_WAIT_ACK_LOW;
					end
					else if (iss.busy)
					begin
						state <= ST_HOLD;
					end
				end
			end

			ST_WAIT_ACK_LOW:
			begin
				if (!fetch_ack)
				begin
					state <= ST_REQ;
				end
			end

			ST_CHANGE_PC:
			begin
				// no fetch until execute resolves the target
				if (iss.redirect_valid)
				begin
					pc <= iss.redirect_pc;
					state <= ST_WAIT_ACK_LOW;
				end
			end

			default:
			begin
				// ST_HOLD, left through issue_now below
			end
			endcase

			if (issue_now)
			begin
				if (issue_src.group == GRP_CTRL)
				begin
					state <= ST_CHANGE_PC;
				end
				else
				begin
					pc <= pc + INSTR_BYTES;
					state <= ST_WAIT_ACK_LOW;
				end
			end
		end
	end

	// payload registers
	always_ff @(posedge clk)
	begin
		if (ack_seen)
		begin
			held_instr <= decoded;
		end
		if (issue_now)
		begin
			iss.issue_instr <= issue_src;
			iss.issue_pc <= pc;
		end
	end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,
	input logic [cpu_pkg::REG_IDX_W-1:0] rd_a_idx,
	output logic [cpu_pkg::DATA_W-1:0] rd_a,
	input logic [cpu_pkg::REG_IDX_W-1:0] rd_b_idx,
	output logic [cpu_pkg::DATA_W-1:0] rd_b,
	input logic wr_en,
	input logic [cpu_pkg::REG_IDX_W-1:0] wr_idx,
	input logic [cpu_pkg::DATA_W-1:0] wr_data
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// combinational read ports
	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// whole file starts at zero
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

//--- design/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
	input logic clk,
	input logic rst,
	issue_if.exec iss,
	output logic retire_valid,
	output logic [cpu_pkg::DATA_W-1:0] retire_pc,
	output logic retire_we,
	output logic [cpu_pkg::REG_IDX_W-1:0] retire_reg,
	output logic [cpu_pkg::DATA_W-1:0] retire_value
);
	import cpu_pkg::*;

	// one-deep stage register
	decoded_instr_t ex_instr;
	logic [DATA_W-1:0] ex_pc;
	logic ex_valid;

	// load/store wait counter
	logic [LDST_CNT_W-1:0] ldst_cnt;

	logic [DATA_W-1:0] dmem [DMEM_WORDS];
	logic [DMEM_IDX_W-1:0] dmem_idx;

	logic [REG_IDX_W-1:0] rd_b_idx;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] imm_ext;
	logic [DATA_W-1:0] eff_addr;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] next_pc;
	logic done;

	// second read port serves rc for alu, ra as store data
	assign rd_b_idx = (ex_instr.group == GRP_STORE) ? ex_instr.ra : ex_instr.rc;

	reg_file u_regs (
		.clk(clk),
		.rst(rst),
		.rd_a_idx(ex_instr.rb),
		.rd_a(op_a),
		.rd_b_idx(rd_b_idx),
		.rd_b(op_b),
		.wr_en(done && retire_we),
		.wr_idx(ex_instr.ra),
		.wr_data(retire_value)
	);

	assign imm_ext = {{(DATA_W - IMM_W){1'b0}}, ex_instr.imm};
	// address wraps inside the small data memory
	assign eff_addr = op_a + imm_ext;
	assign dmem_idx = eff_addr[DMEM_IDX_W-1:0];

	// alu ops complete at once, loads and stores after the counter drains
	assign done = ex_valid && (ldst_cnt == '0);
	assign iss.busy = (ldst_cnt != '0);

	always_comb
	begin
		case (alu_op_e'(ex_instr.oper))
		OP_ADD: alu_result = op_a + op_b;
		OP_SUB: alu_result = op_a - op_b;
		OP_AND: alu_result = op_a & op_b;
		OP_OR: alu_result = op_a | op_b;
		OP_XOR: alu_result = op_a ^ op_b;
		OP_ADDI: alu_result = op_a + imm_ext;
		default: alu_result = '0;
		endcase
	end

	// branch resolution, fall through on unknown opcode
	always_comb
	begin
		next_pc = ex_pc + INSTR_BYTES;
		case (ctrl_op_e'(ex_instr.oper))
		OP_JMP: next_pc = imm_ext;
		OP_BEQZ:
		begin
			if (op_a == '0)
			begin
				next_pc = imm_ext;
			end
		end
		default: next_pc = ex_pc + INSTR_BYTES;
		endcase
	end

	assign iss.redirect_valid = done && (ex_instr.group == GRP_CTRL);
	assign iss.redirect_pc = next_pc;

	always_comb
	begin
		retire_valid = done;
		retire_pc = ex_pc;
		retire_we = 1'b0;
		retire_value = alu_result;
		case (ex_instr.group)
		GRP_ALU: retire_we = 1'b1;
		GRP_CTRL: retire_value = next_pc;
		GRP_LOAD:
		begin
			retire_we = 1'b1;
			retire_value = dmem[dmem_idx];
		end
		default: retire_value = op_b;
		endcase
		// no destination reported for stores and branches
		retire_reg = retire_we ? ex_instr.ra : '0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_valid <= 1'b0;
			ldst_cnt <= '0;
			for (int i = 0; i < DMEM_WORDS; i++)
			begin
				dmem[i] <= '0;
			end
		end
		else
		begin
			if (ldst_cnt != '0)
			begin
				ldst_cnt <= ldst_cnt - 1'b1;
			end
			if (done)
			begin
				ex_valid <= 1'b0;
				if (ex_instr.group == GRP_STORE)
				begin
					dmem[dmem_idx] <= op_b;
				end
			end
			if (iss.issue_valid)
			begin
				ex_valid <= 1'b1;
				// busy for the remaining load/store cycles
				if (iss.issue_instr.group inside {GRP_LOAD, GRP_STORE})
				begin
					ldst_cnt <= LDST_CNT_W'(LDST_CYCLES - 1);
				end
			end
		end
	end

	// issued instruction, payload only
	always_ff @(posedge clk)
	begin
		if (iss.issue_valid)
		begin
			ex_instr <= iss.issue_instr;
			ex_pc <= iss.issue_pc;
		end
	end

endmodule

//--- design/cpu_front.sv
`timescale 1ns/1ps

module cpu_front (
	input logic clk,
	input logic rst,
	output logic fetch_req,
	output logic [cpu_pkg::DATA_W-1:0] fetch_addr,
	input logic fetch_ack,
	input logic [cpu_pkg::DATA_W-1:0] fetch_data,
	output logic retire_valid,
	output logic [cpu_pkg::DATA_W-1:0] retire_pc,
	output logic retire_we,
	output logic [cpu_pkg::REG_IDX_W-1:0] retire_reg,
	output logic [cpu_pkg::DATA_W-1:0] retire_value
);

	// decoded instructions forward, stall and redirect back
	issue_if iss_bus ();

	fetch_decode_stage u_fetch_decode (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_ack(fetch_ack),
		.fetch_data(fetch_data),
		.iss(iss_bus.stage)
	);

	exec_stage u_exec (
		.clk(clk),
		.rst(rst),
		.iss(iss_bus.exec),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_reg(retire_reg),
		.retire_value(retire_value)
	);

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// 20 ns period, first rising edge at 10 ns
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// reset held over the first four rising edges
	initial
	begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- sim/cpu_front_tb.sv
`timescale 1ns/1ps

module cpu_front_tb;
	import cpu_pkg::*;

	// layout of the data file image
	localparam int PROG_WORDS = 16;
	localparam int COUNT_AT = 16;
	localparam int RECORDS_AT = 17;
	localparam int MAX_RECORDS = 32;

	logic clk;
	logic rst;

	// fetch port, memory side
	logic fetch_req;
	logic [DATA_W-1:0] fetch_addr;
	logic fetch_ack = 1'b0;
	logic [DATA_W-1:0] fetch_data = '0;

	// retire port
	logic retire_valid;
	logic [DATA_W-1:0] retire_pc;
	logic retire_we;
	logic [REG_IDX_W-1:0] retire_reg;
	logic [DATA_W-1:0] retire_value;

	logic [DATA_W-1:0] image [256];
	int num_expected = 0;
	logic image_loaded = 1'b0;

	// memory model delay state
	logic counting = 1'b0;
	logic [1:0] delay_left = '0;

	// monitor state
	int retired = 0;
	int fetch_checks = 0;
	logic req_prev = 1'b0;
	logic [DATA_W-1:0] addr_prev = '0;
	logic [DATA_W-1:0] expected_fetch = '0;
	logic awaiting_redirect = 1'b0;
	logic target_pending = 1'b0;
	logic [DATA_W-1:0] ctrl_pc = '0;
	logic [DATA_W-1:0] fetched_word;
	logic [DATA_W-1:0] exp_pc;
	logic exp_we;
	logic [REG_IDX_W-1:0] exp_reg;
	logic [DATA_W-1:0] exp_value;

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	cpu_front dut (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_ack(fetch_ack),
		.fetch_data(fetch_data),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_reg(retire_reg),
		.retire_value(retire_value)
	);

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// program area only, zero words beyond it
	function automatic logic [DATA_W-1:0] word_at(input logic [DATA_W-1:0] addr);
		if (addr < DATA_W'(PROG_WORDS * INSTR_BYTES))
		begin
			return image[8'(addr[DATA_W-1:2])];
		end
		return '0;
	endfunction

	// field f of expected record k
	function automatic logic [DATA_W-1:0] record_field(input int k, input int f);
		return image[8'(RECORDS_AT + 4 * k + f)];
	endfunction

	task automatic compare_retire(
		input string name,
		input logic [DATA_W-1:0] want_pc,
		input logic want_we,
		input logic [REG_IDX_W-1:0] want_reg,
		input logic [DATA_W-1:0] want_value
	);
		if (retire_pc !== want_pc)
		begin
			$display("FAILED %s pc expected %h actual %h", name, want_pc, retire_pc);
			abort_run();
		end
		else if (retire_we !== want_we)
		begin
			$display("FAILED %s we expected %b actual %b", name, want_we, retire_we);
			abort_run();
		end
		else if (retire_reg !== want_reg)
		begin
			$display("FAILED %s reg expected %0d actual %0d", name, want_reg, retire_reg);
			abort_run();
		end
		else if (retire_value !== want_value)
		begin
			$display("FAILED %s value expected %h actual %h", name, want_value, retire_value);
			abort_run();
		end
	endtask

	task automatic compare_fetch(
		input string name,
		input logic [DATA_W-1:0] want_addr,
		input logic [DATA_W-1:0] got_addr
	);
		if (got_addr !== want_addr)
		begin
			$display("FAILED %s addr expected %h actual %h", name, want_addr, got_addr);
			abort_run();
		end
	endtask

	// instruction memory, word answered after 0 to 3 extra cycles
	always @(posedge clk)
	begin
		if (rst)
		begin
			fetch_ack <= 1'b0;
			fetch_data <= '0;
			counting <= 1'b0;
			delay_left <= '0;
		end
		else if (fetch_ack)
		begin
			// hold word and ack until the request falls
			if (!fetch_req)
			begin
				fetch_ack <= 1'b0;
			end
		end
		else if (fetch_req && !counting)
		begin
			counting <= 1'b1;
			delay_left <= 2'($urandom % 4);
		end
		else if (counting)
		begin
			if (delay_left == 2'd0)
			begin
				counting <= 1'b0;
				fetch_ack <= 1'b1;
				fetch_data <= word_at(fetch_addr);
			end
			else
			begin
				delay_left <= delay_left - 2'd1;
			end
		end
	end

	// monitors sampled mid-cycle
	always @(negedge clk)
	begin
		if (rst)
		begin
			if (fetch_req !== 1'b0 || retire_valid !== 1'b0)
			begin
				$display("fetch request or retire seen while reset is asserted");
				abort_run();
			end
		end
		else
		begin
			// retire in program order against the file
			if (retire_valid === 1'b1)
			begin
				if (retired >= num_expected)
				begin
					$display("retire seen after all expected records were used");
					abort_run();
				end
				exp_pc = record_field(retired, 0);
				exp_we = (record_field(retired, 1) != '0);
				exp_reg = REG_IDX_W'(record_field(retired, 2));
				exp_value = record_field(retired, 3);
				compare_retire($sformatf("retire %0d", retired), exp_pc, exp_we, exp_reg,
					exp_value);
				// control op resolved, target becomes next fetch
				if (awaiting_redirect && exp_pc == ctrl_pc)
				begin
					expected_fetch = exp_value;
					awaiting_redirect = 1'b0;
					target_pending = 1'b1;
				end
				retired = retired + 1;
			end

			// four-phase fetch rules
			if (fetch_req === 1'b1 && !req_prev)
			begin
				if (fetch_ack !== 1'b0)
				begin
					$display("fetch request raised while acknowledge still high");
					abort_run();
				end
				if (awaiting_redirect)
				begin
					$display("fetch request made before the control redirect");
					abort_run();
				end
				compare_fetch($sformatf("fetch %0d", fetch_checks), expected_fetch, fetch_addr);
				fetch_checks = fetch_checks + 1;
				target_pending = 1'b0;
				fetched_word = word_at(fetch_addr);
				if (instr_group_e'(fetched_word[GROUP_LSB +: GROUP_W]) == GRP_CTRL)
				begin
					awaiting_redirect = 1'b1;
					ctrl_pc = fetch_addr;
				end
				else
				begin
					expected_fetch = fetch_addr + INSTR_BYTES;
				end
			end
			else if (fetch_req === 1'b1 && fetch_addr !== addr_prev)
			begin
				$display("fetch address changed while request was high");
				abort_run();
			end
		end
		req_prev = (fetch_req === 1'b1);
		addr_prev = fetch_addr;
	end

	// watchdog sized from the record count
	initial
	begin
		wait (image_loaded);
		repeat ((num_expected + 16) * 12) @(posedge clk);
		$display("timeout, only %0d of %0d records retired", retired, num_expected);
		abort_run();
	end

	initial
	begin
		void'($urandom(32'h970a_e85c));
		$readmemh("sim/program_input.mem", image);
		if ($isunknown(image[8'(COUNT_AT)]) || image[8'(COUNT_AT)] == '0
			|| image[8'(COUNT_AT)] > DATA_W'(MAX_RECORDS))
		begin
			$display("data file missing or record count out of range");
			abort_run();
		end
		else
		begin
			num_expected = int'(image[8'(COUNT_AT)]);
			image_loaded = 1'b1;
			wait (retired == num_expected);
			// a final control op still owes its target on the fetch port
			wait (!target_pending);
			@(posedge clk);
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- sim/program_input.mem
// words 0-15: program image at byte address 4*index, zero words are nops
// word 16: record count N, then N records with columns pc we reg value
29000005
2A00000C
03280000
00000000
0C440000
25700000
48000024
2E000BAD
2F000BAD
C3200004
87000009
1EF00000
4820003C
12D40000
40000040
2E00DEAD
0000000C
// expected retire records
00000000 1 1 00000005
00000004 1 2 0000000C
00000008 1 3 00000011
00000010 1 4 00000007
00000014 1 5 00000016
00000018 0 0 00000024
00000024 0 0 00000011
00000028 1 7 00000011
0000002C 1 6 00000017
00000030 0 0 00000034
00000034 1 2 00000016
00000038 0 0 00000040

//--- build.f
design/cpu_pkg.sv
design/issue_if.sv
design/instr_decoder.sv
design/fetch_decode_stage.sv
design/reg_file.sv
design/exec_stage.sv
design/cpu_front.sv
sim/tb_clock.sv
sim/cpu_front_tb.sv

//--- Makefile
SOURCES := $(wildcard design/*.sv sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcpu_front_tb: build.f $(SOURCES)
	verilator --binary --timing -f build.f --top-module cpu_front_tb -Mdir obj_dir

sim.log: obj_dir/Vcpu_front_tb sim/program_input.mem
	-./obj_dir/Vcpu_front_tb > sim.log 2>&1

run: obj_dir/Vcpu_front_tb sim/program_input.mem
	-./obj_dir/Vcpu_front_tb > sim.log 2>&1
	cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
